/* common/tcp_rx_pkg.sv */
`default_nettype none

package tcp_rx_pkg;

    localparam int data_bytes = 8;

    // One stream word, lane 0 in bits 7:0
    typedef logic [8*data_bytes-1:0] beat_t;

    localparam logic [15:0] ethertype_ipv4    = 16'h0800;
    localparam logic [7:0]  ip_proto_tcp      = 8'd6;
    localparam logic [3:0]  ipv4_ihl          = 4'd5;
    localparam int          eth_hdr_bytes     = 14;
    localparam int          ip_hdr_bytes      = 20;
    localparam int          tcp_min_hdr_bytes = 20;

    // Bits of the TCP flags byte
    localparam int flag_fin = 0;
    localparam int flag_syn = 1;
    localparam int flag_rst = 2;
    localparam int flag_ack = 4;

    ////////////////////
    // Header beat layouts
    ////////////////////

    // Fields listed in wire order, valid once lane 0 sits in the top byte
    typedef struct packed {
        logic [31:0] src_mac_tail;
        logic [15:0] ethertype;
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
    } hdr_b1_t;

    typedef struct packed {
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
    } hdr_b2_t;

    typedef struct packed {
        logic [15:0] ip_csum;
        logic [31:0] src_ip;
        logic [15:0] dst_ip_head;
    } hdr_b3_t;

    typedef struct packed {
        logic [15:0] dst_ip_tail;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] seq_head;
    } hdr_b4_t;

    typedef struct packed {
        logic [15:0] seq_tail;
        logic [31:0] ack_num;
        logic [3:0]  data_off;
        logic [3:0]  rsvd;
        logic [7:0]  flags;
    } hdr_b5_t;

    typedef union packed {
        hdr_b1_t b1;
        hdr_b2_t b2;
        hdr_b3_t b3;
        hdr_b4_t b4;
        hdr_b5_t b5;
    } hdr_beat_t;

endpackage

`default_nettype wire

/* tcp_rx/tcp_header_parser.sv */
`default_nettype none

module tcp_header_parser #(
    parameter logic [47:0] board_mac  = 48'h02_00_c0_a8_0a_0a,
    parameter logic [15:0] local_port = 16'h0024
) (
    input  wire                                 aclk,
    input  wire                                 areset,
    input  wire tcp_rx_pkg::beat_t              in_tdata,
    input  wire [tcp_rx_pkg::data_bytes-1:0]    in_tkeep,
    input  wire                                 in_tlast,
    input  wire                                 beat_fire,
    input  wire                                 established,
    input  wire [31:0]                          expected_seq,
    output logic                                win_valid,
    output logic                                win_accept,
    output logic [15:0]                         win_start,
    output logic [15:0]                         win_len,
    output logic                                seg_valid,
    output logic                                seg_syn,
    output logic                                seg_fin,
    output logic                                seg_ack,
    output logic                                seg_rst,
    output logic [31:0]                         seg_seq,
    output logic [31:0]                         seg_ack_num,
    output logic [47:0]                         peer_mac,
    output logic [31:0]                         peer_ip,
    output logic [15:0]                         peer_port,
    output logic [15:0]                         peer_window,
    output logic [15:0]                         seg_payload_len
);
    import tcp_rx_pkg::*;

    logic [2:0]  beat_cnt;
    logic        hdr_fire;
    beat_t       net;
    hdr_beat_t   hdr;

    logic        mac_ok;
    logic        type_ok;
    logic        proto_ok;
    logic        port_ok;
    logic        frame_match;
    logic        reached_win;

    logic [15:0] total_len;
    logic [15:0] seq_head;
    logic [31:0] seq_num;
    logic [7:0]  flags;
    logic [15:0] tcp_hdr_len;
    logic [15:0] payload_len;
    logic        accept;

    // Lane 0 moves to the top byte so fields read in network order
    assign net = {<<8{in_tdata}};
    assign hdr = net;

    // Empty beats carry no header bytes
    assign hdr_fire = beat_fire && in_tkeep[0];

    assign frame_match = mac_ok && type_ok && proto_ok && port_ok;
    assign reached_win = beat_cnt[2] && beat_cnt[1];

    ////////////////////
    // Beat 5 decisions
    ////////////////////

    assign flags       = hdr.b5.flags;
    assign seq_num     = {seq_head, hdr.b5.seq_tail};
    assign tcp_hdr_len = {10'd0, hdr.b5.data_off, 2'b00};
    assign payload_len = total_len - 16'(ip_hdr_bytes) - tcp_hdr_len;

    assign accept = frame_match && established
                    && flags[flag_ack] && !flags[flag_fin]
                    && payload_len != 16'd0
                    && seq_num == expected_seq
                    && tcp_hdr_len >= 16'(tcp_min_hdr_bytes);

    ////////////////////
    // Beat count and pulses
    ////////////////////

    always_ff @(posedge aclk) begin
        if (areset) begin
            beat_cnt  <= '0;
            win_valid <= 1'b0;
            seg_valid <= 1'b0;
        end else begin
            // No window for a frame that stops at beat 5
            win_valid <= beat_fire && beat_cnt == 3'd5 && !in_tlast;
            seg_valid <= beat_fire && in_tlast && reached_win && frame_match;
            if (beat_fire) begin
                if (in_tlast) begin
                    beat_cnt <= '0;
                end else if (beat_cnt != 3'd7) begin
                    beat_cnt <= beat_cnt + 3'd1;
                end
            end
        end
    end

    ////////////////////
    // Field capture
    ////////////////////

    always_ff @(posedge aclk) begin
        if (hdr_fire) begin
            case (beat_cnt)
                3'd0: begin
                    mac_ok          <= net[63:16] == board_mac;
                    peer_mac[47:32] <= net[15:0];
                end
                3'd1: begin
                    peer_mac[31:0] <= hdr.b1.src_mac_tail;
                    type_ok        <= hdr.b1.ethertype == ethertype_ipv4
                                      && hdr.b1.ihl == ipv4_ihl;
                end
                3'd2: begin
                    total_len <= hdr.b2.total_len;
                    proto_ok  <= hdr.b2.protocol == ip_proto_tcp;
                end
                3'd3: begin
                    peer_ip <= hdr.b3.src_ip;
                end
                3'd4: begin
                    peer_port <= hdr.b4.src_port;
                    port_ok   <= hdr.b4.dst_port == local_port;
                    seq_head  <= hdr.b4.seq_head;
                end
                3'd5: begin
                    seg_seq         <= seq_num;
                    seg_ack_num     <= hdr.b5.ack_num;
                    seg_fin         <= flags[flag_fin];
                    seg_syn         <= flags[flag_syn];
                    seg_rst         <= flags[flag_rst];
                    seg_ack         <= flags[flag_ack];
                    seg_payload_len <= payload_len;
                    win_len         <= payload_len;
                    // Options are skipped, payload follows the whole TCP header
                    win_start       <= 16'(eth_hdr_bytes + ip_hdr_bytes) + tcp_hdr_len;
                    win_accept      <= accept;
                end
                3'd6: begin
                    peer_window <= net[63:48];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tcp_rx/tcp_payload_aligner.sv */
`default_nettype none

module tcp_payload_aligner (
    input  wire                                 aclk,
    input  wire                                 areset,
    input  wire tcp_rx_pkg::beat_t              in_tdata,
    input  wire [tcp_rx_pkg::data_bytes-1:0]    in_tkeep,
    input  wire                                 in_tvalid,
    input  wire                                 in_tlast,
    output logic                                in_tready,
    input  wire                                 win_valid,
    input  wire                                 win_accept,
    input  wire [15:0]                          win_start,
    input  wire [15:0]                          win_len,
    output tcp_rx_pkg::beat_t                   out_tdata,
    output logic [tcp_rx_pkg::data_bytes-1:0]   out_tkeep,
    output logic                                out_tlast,
    output logic                                out_tvalid,
    input  wire                                 out_tready
);
    import tcp_rx_pkg::*;

    localparam int lane_w = $clog2(data_bytes);
    localparam int word_w = 8 * data_bytes;

    logic                  can_load;
    logic                  fire;
    logic [15:0]           pos;
    logic                  acc_q;
    logic [15:0]           start_q;
    logic [15:0]           len_q;
    logic                  acc;
    logic [15:0]           w_start;
    logic [15:0]           w_end;

    logic [data_bytes-1:0] sel;
    logic [lane_w-1:0]     lo;
    logic [lane_w:0]       n;
    beat_t                 picked;
    beat_t                 shifted;

    beat_t                 carry;
    beat_t                 carry_m;
    beat_t                 carry_eff;
    logic [lane_w-1:0]     carry_cnt;
    logic [lane_w-1:0]     c_eff;
    logic [2*word_w-1:0]   joined;
    logic [lane_w:0]       total;
    logic                  full;
    logic                  spill;
    logic                  seg_end;
    logic                  flush_q;
    logic                  load_flush;
    logic                  load_word;

    function automatic logic [data_bytes-1:0] keep_of(input logic [lane_w:0] cnt);
        logic [data_bytes-1:0] k;
        k = '0;
        for (int i = 0; i < data_bytes; i++) begin
            k[i] = i < int'(cnt);
        end
        return k;
    endfunction

    assign can_load  = !out_tvalid || out_tready;
    assign in_tready = can_load;
    assign fire      = in_tvalid && can_load;

    // Window bypass for the beat that arrives with win_valid
    assign acc     = win_valid ? win_accept : acc_q;
    assign w_start = win_valid ? win_start : start_q;
    assign w_end   = w_start + (win_valid ? win_len : len_q);

    ////////////////////
    // Lane selection
    ////////////////////

    always_comb begin
        sel    = '0;
        picked = '0;
        lo     = '0;
        n      = '0;
        // Downward so lo ends on the lowest selected lane
        for (int i = data_bytes - 1; i >= 0; i--) begin
            if (acc && in_tkeep[i] && pos + 16'(i) >= w_start && pos + 16'(i) < w_end) begin
                sel[i]           = 1'b1;
                picked[8*i +: 8] = in_tdata[8*i +: 8];
                lo               = lane_w'(i);
                n                = n + 1'b1;
            end
        end
    end

    always_comb begin
        carry_m = '0;
        for (int i = 0; i < data_bytes; i++) begin
            if (i < int'(carry_cnt)) begin
                carry_m[8*i +: 8] = carry[8*i +: 8];
            end
        end
    end

    assign shifted   = picked >> {lo, 3'b000};
    assign carry_eff = flush_q ? '0 : carry_m;
    assign c_eff     = flush_q ? '0 : carry_cnt;
    assign joined    = {{word_w{1'b0}}, carry_eff}
                       | ({{word_w{1'b0}}, shifted} << {c_eff, 3'b000});
    assign total     = {1'b0, c_eff} + n;
    assign full      = total[lane_w];
    assign spill     = full && total[lane_w-1:0] != '0;

    // Last payload byte in this beat, or a frame cut short
    assign seg_end = (|sel && pos + 16'(data_bytes) >= w_end) || (in_tlast && total != '0);

    assign load_flush = flush_q && can_load;
    assign load_word  = fire && (full || (seg_end && total != '0));

    ////////////////////
    // Control state
    ////////////////////

    always_ff @(posedge aclk) begin
        if (areset) begin
            out_tvalid <= 1'b0;
            flush_q    <= 1'b0;
            carry_cnt  <= '0;
            acc_q      <= 1'b0;
            pos        <= '0;
        end else begin
            if (out_tready) begin
                out_tvalid <= 1'b0;
            end
            if (load_flush || load_word) begin
                out_tvalid <= 1'b1;
            end
            if (win_valid) begin
                acc_q <= win_accept;
            end
            if (fire) begin
                pos       <= in_tlast ? '0 : pos + 16'(data_bytes);
                flush_q   <= seg_end && spill;
                carry_cnt <= (seg_end && !spill) ? '0 : total[lane_w-1:0];
                if (in_tlast) begin
                    acc_q <= 1'b0;
                end
            end else if (load_flush) begin
                flush_q   <= 1'b0;
                carry_cnt <= '0;
            end
        end
    end

    ////////////////////
    // Data path
    ////////////////////

    always_ff @(posedge aclk) begin
        if (win_valid) begin
            start_q <= win_start;
            len_q   <= win_len;
        end
        if (load_flush) begin
            out_tdata <= carry_m;
            out_tkeep <= keep_of({1'b0, carry_cnt});
            out_tlast <= 1'b1;
        end else if (load_word) begin
            out_tdata <= joined[word_w-1:0];
            out_tkeep <= full ? '1 : keep_of(total);
            out_tlast <= seg_end && !spill;
        end
        if (fire) begin
            carry <= full ? joined[2*word_w-1:word_w] : joined[word_w-1:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/tcp_rx_top.sv */
`default_nettype none

module tcp_rx_top #(
    parameter logic [47:0] board_mac  = 48'h02_00_c0_a8_0a_0a,
    parameter logic [15:0] local_port = 16'h0024
) (
    input  wire                                 aclk,
    input  wire                                 areset,
    input  wire tcp_rx_pkg::beat_t              in_tdata,
    input  wire [tcp_rx_pkg::data_bytes-1:0]    in_tkeep,
    input  wire                                 in_tvalid,
    input  wire                                 in_tlast,
    output logic                                in_tready,
    input  wire                                 established,
    input  wire [31:0]                          expected_seq,
    output tcp_rx_pkg::beat_t                   out_tdata,
    output logic [tcp_rx_pkg::data_bytes-1:0]   out_tkeep,
    output logic                                out_tlast,
    output logic                                out_tvalid,
    input  wire                                 out_tready,
    output logic                                seg_valid,
    output logic                                seg_syn,
    output logic                                seg_fin,
    output logic                                seg_ack,
    output logic                                seg_rst,
    output logic [31:0]                         seg_seq,
    output logic [31:0]                         seg_ack_num,
    output logic [47:0]                         peer_mac,
    output logic [31:0]                         peer_ip,
    output logic [15:0]                         peer_port,
    output logic [15:0]                         peer_window,
    output logic [15:0]                         seg_payload_len
);

    logic        beat_fire;
    logic        win_valid;
    logic        win_accept;
    logic [15:0] win_start;
    logic [15:0] win_len;

    // Input handshake seen by the parser
    assign beat_fire = in_tvalid && in_tready;

    tcp_header_parser #(
        .board_mac (board_mac),
        .local_port(local_port)
    ) parser_i (
        .aclk           (aclk),
        .areset         (areset),
        .in_tdata       (in_tdata),
        .in_tkeep       (in_tkeep),
        .in_tlast       (in_tlast),
        .beat_fire      (beat_fire),
        .established    (established),
        .expected_seq   (expected_seq),
        .win_valid      (win_valid),
        .win_accept     (win_accept),
        .win_start      (win_start),
        .win_len        (win_len),
        .seg_valid      (seg_valid),
        .seg_syn        (seg_syn),
        .seg_fin        (seg_fin),
        .seg_ack        (seg_ack),
        .seg_rst        (seg_rst),
        .seg_seq        (seg_seq),
        .seg_ack_num    (seg_ack_num),
        .peer_mac       (peer_mac),
        .peer_ip        (peer_ip),
        .peer_port      (peer_port),
        .peer_window    (peer_window),
        .seg_payload_len(seg_payload_len)
    );

    tcp_payload_aligner aligner_i (
        .aclk      (aclk),
        .areset    (areset),
        .in_tdata  (in_tdata),
        .in_tkeep  (in_tkeep),
        .in_tvalid (in_tvalid),
        .in_tlast  (in_tlast),
        .in_tready (in_tready),
        .win_valid (win_valid),
        .win_accept(win_accept),
        .win_start (win_start),
        .win_len   (win_len),
        .out_tdata (out_tdata),
        .out_tkeep (out_tkeep),
        .out_tlast (out_tlast),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready)
    );

endmodule

`default_nettype wire

/* test/tb_tcp_rx_model.svh */
`ifndef TB_TCP_RX_MODEL_SVH
`define TB_TCP_RX_MODEL_SVH

// Expected segment report in DUT port order
typedef struct packed {
    logic        syn;
    logic        fin;
    logic        ack;
    logic        rst;
    logic [31:0] seq;
    logic [31:0] ack_num;
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
    logic [15:0] window;
    logic [15:0] len;
} report_t;

logic [7:0] frame[$];
report_t    exp_reports[$];
// Bit 8 marks the last byte of a segment
logic [8:0] exp_bytes[$];

// Pushes a field most significant byte first
function automatic void push_field(input logic [63:0] value, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
        frame.push_back(value[8*i +: 8]);
    end
endfunction

task automatic build_frame(input logic est, input logic [31:0] want_seq);
    int          fault;
    int          opt_len;
    int          pay_len;
    int          cut;
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
    logic [3:0]  ihl;
    logic [7:0]  proto;
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq;
    logic [31:0] ack_num;
    logic [7:0]  flags;
    logic [15:0] window;
    logic [7:0]  b;
    logic        match;
    logic        accept;
    report_t     rep;

    // Values 0 to 5 each pick one fault
    fault     = $urandom_range(0, 9);
    dst_mac   = (fault == 0) ? board_mac ^ (48'd1 << $urandom_range(0, 47)) : board_mac;
    ethertype = (fault == 1) ? 16'h86dd : 16'h0800;
    proto     = (fault == 2) ? 8'd17 : 8'd6;
    dst_port  = (fault == 3) ? ~local_port : local_port;
    ihl       = (fault == 4) ? 4'd6 : 4'd5;
    cut       = $urandom_range(1, 47);
    opt_len   = 4 * $urandom_range(0, 10);
    pay_len   = $urandom_range(0, 200);
    src_mac   = {16'($urandom), $urandom};
    src_ip    = $urandom;
    src_port  = 16'($urandom);
    ack_num   = $urandom;
    window    = 16'($urandom);
    seq       = ($urandom_range(0, 3) == 0) ? $urandom : want_seq;
    flags     = ($urandom_range(0, 3) == 0) ? 8'($urandom) : 8'h18;

    match  = dst_mac == board_mac && ethertype == 16'h0800 && ihl == 4'd5
             && proto == 8'd6 && dst_port == local_port && fault != 5;
    accept = match && est && flags[4] && !flags[0] && pay_len != 0 && seq == want_seq;

    frame.delete();
    push_field(dst_mac, 6);
    push_field(src_mac, 6);
    push_field(ethertype, 2);
    push_field({4'd4, ihl, 8'h00}, 2);
    push_field(16'(40 + opt_len + pay_len), 2);
    push_field({$urandom, 8'd64, proto, 16'($urandom)}, 8);
    push_field({src_ip, $urandom}, 8);
    push_field({src_port, dst_port, seq}, 8);
    push_field(ack_num, 4);
    push_field({4'(5 + opt_len / 4), 4'h0, flags, window}, 4);
    push_field($urandom, 4);
    for (int i = 0; i < opt_len; i++) begin
        frame.push_back(8'($urandom));
    end
    for (int i = 0; i < pay_len; i++) begin
        b = 8'($urandom);
        frame.push_back(b);
        if (accept) begin
            exp_bytes.push_back({i == pay_len - 1, b});
        end
    end
    // Random padding up to the Ethernet minimum
    while (frame.size() < 60) begin
        frame.push_back(8'($urandom));
    end
    if (fault == 5) begin
        while (frame.size() > cut) begin
            void'(frame.pop_back());
        end
    end

    if (match) begin
        rep.syn     = flags[1];
        rep.fin     = flags[0];
        rep.ack     = flags[4];
        rep.rst     = flags[2];
        rep.seq     = seq;
        rep.ack_num = ack_num;
        rep.mac     = src_mac;
        rep.ip      = src_ip;
        rep.port    = src_port;
        rep.window  = window;
        rep.len     = 16'(pay_len);
        exp_reports.push_back(rep);
    end
endtask

`endif

/* test/tb_tcp_rx.sv */
`default_nettype none

module tb_tcp_rx;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [47:0] board_mac    = 48'h02_11_22_33_44_55;
    localparam logic [15:0] local_port   = 16'h1f90;
    localparam int          num_frames   = 300;
    localparam int          seed         = 32'h64a97502;
    // 40 beats per frame at most, 4 ns clock, margin of 4
    localparam int          run_limit_ns = num_frames * 40 * 4 * 4;

    logic        aclk;
    logic        areset;
    logic [63:0] in_tdata;
    logic [7:0]  in_tkeep;
    logic        in_tvalid;
    logic        in_tlast;
    logic        in_tready;
    logic        established;
    logic [31:0] expected_seq;
    logic [63:0] out_tdata;
    logic [7:0]  out_tkeep;
    logic        out_tlast;
    logic        out_tvalid;
    logic        out_tready;
    logic        seg_valid;
    logic        seg_syn;
    logic        seg_fin;
    logic        seg_ack;
    logic        seg_rst;
    logic [31:0] seg_seq;
    logic [31:0] seg_ack_num;
    logic [47:0] peer_mac;
    logic [31:0] peer_ip;
    logic [15:0] peer_port;
    logic [15:0] peer_window;
    logic [15:0] seg_payload_len;

    `include "tb_tcp_rx_model.svh"

    tcp_rx_top #(
        .board_mac (board_mac),
        .local_port(local_port)
    ) dut_i (
        .aclk           (aclk),
        .areset         (areset),
        .in_tdata       (in_tdata),
        .in_tkeep       (in_tkeep),
        .in_tvalid      (in_tvalid),
        .in_tlast       (in_tlast),
        .in_tready      (in_tready),
        .established    (established),
        .expected_seq   (expected_seq),
        .out_tdata      (out_tdata),
        .out_tkeep      (out_tkeep),
        .out_tlast      (out_tlast),
        .out_tvalid     (out_tvalid),
        .out_tready     (out_tready),
        .seg_valid      (seg_valid),
        .seg_syn        (seg_syn),
        .seg_fin        (seg_fin),
        .seg_ack        (seg_ack),
        .seg_rst        (seg_rst),
        .seg_seq        (seg_seq),
        .seg_ack_num    (seg_ack_num),
        .peer_mac       (peer_mac),
        .peer_ip        (peer_ip),
        .peer_port      (peer_port),
        .peer_window    (peer_window),
        .seg_payload_len(seg_payload_len)
    );

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Beats of the current frame, tvalid held until the handshake
    task automatic send_frame();
        int   nbeats;
        int   b;
        int   idx;
        logic taken;
        nbeats = (frame.size() + 7) / 8;
        b = 0;
        while (b < nbeats) begin
            if (!in_tvalid && $urandom_range(0, 3) != 0) begin
                for (int i = 0; i < 8; i++) begin
                    idx = 8 * b + i;
                    in_tkeep[i] = idx < frame.size();
                    in_tdata[8*i +: 8] = (idx < frame.size()) ? frame[idx] : 8'h00;
                end
                in_tlast  = b == nbeats - 1;
                in_tvalid = 1'b1;
            end
            @(posedge aclk);
            taken = in_tvalid && in_tready;
            #1;
            if (taken) begin
                b++;
                in_tvalid = 1'b0;
            end
        end
        in_tdata = '0;
        in_tkeep = '0;
        in_tlast = 1'b0;
    endtask

    // Random back-pressure
    always @(posedge aclk) begin
        #1;
        out_tready = $urandom_range(0, 3) != 0;
    end

    ////////////////////
    // Monitors
    ////////////////////

    always @(posedge aclk) begin : report_monitor
        report_t got;
        report_t want;
        if (!areset && seg_valid) begin
            got = {seg_syn, seg_fin, seg_ack, seg_rst, seg_seq, seg_ack_num, peer_mac,
                   peer_ip, peer_port, peer_window, seg_payload_len};
            assert (exp_reports.size() != 0)
            else stop_run($sformatf("CHECK FAILED at %0t: unexpected report %h", $time, got));
            want = exp_reports.pop_front();
            assert (got == want)
            else stop_run($sformatf("CHECK FAILED at %0t: report %h, expected %h",
                                    $time, got, want));
        end
    end

    always @(posedge aclk) begin : payload_monitor
        int         top;
        logic [8:0] mask;
        logic [8:0] want;
        if (!areset && out_tvalid && out_tready) begin
            top = -1;
            for (int i = 0; i < 8; i++) begin
                if (out_tkeep[i]) begin
                    top = i;
                end
            end
            mask = (9'd1 << (top + 1)) - 9'd1;
            assert (top >= 0 && out_tkeep == mask[7:0])
            else stop_run($sformatf("CHECK FAILED at %0t: tkeep %b", $time, out_tkeep));
            for (int i = 0; i <= top; i++) begin
                assert (exp_bytes.size() != 0)
                else stop_run($sformatf("CHECK FAILED at %0t: extra payload byte in lane %0d",
                                        $time, i));
                want = exp_bytes.pop_front();
                assert (out_tdata[8*i +: 8] == want[7:0] && (out_tlast && i == top) == want[8])
                else stop_run($sformatf("CHECK FAILED at %0t: lane %0d byte %h last %b, exp %h",
                                        $time, i, out_tdata[8*i +: 8], out_tlast, want));
            end
        end
    end

    initial begin : watchdog
        #(run_limit_ns);
        stop_run($sformatf("Timeout: the run did not finish within %0d ns", run_limit_ns));
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        int gap;
        void'($urandom(seed));
        areset       = 1'b1;
        in_tdata     = '0;
        in_tkeep     = '0;
        in_tvalid    = 1'b0;
        in_tlast     = 1'b0;
        established  = 1'b0;
        expected_seq = '0;
        out_tready   = 1'b0;
        repeat (10) @(posedge aclk);
        #1;
        areset = 1'b0;
        repeat (3) begin
            @(posedge aclk);
            assert (!out_tvalid && !seg_valid && in_tready)
            else stop_run($sformatf("CHECK FAILED at %0t: outputs not idle after reset", $time));
        end
        #1;
        for (int f = 0; f < num_frames; f++) begin
            established  = $urandom_range(0, 7) != 0;
            expected_seq = $urandom;
            build_frame(established, expected_seq);
            send_frame();
            gap = $urandom_range(0, 3);
            repeat (gap) @(posedge aclk);
            #1;
        end
        for (int i = 0; i < 500 && (exp_bytes.size() != 0 || exp_reports.size() != 0); i++) begin
            @(posedge aclk);
        end
        // Time for any stray output to show up
        repeat (20) @(posedge aclk);
        if (exp_bytes.size() == 0 && exp_reports.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run($sformatf("CHECK FAILED at %0t: %0d bytes and %0d reports never arrived",
                               $time, exp_bytes.size(), exp_reports.size()));
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+test
common/tcp_rx_pkg.sv
tcp_rx/tcp_header_parser.sv
tcp_rx/tcp_payload_aligner.sv
verilog/tcp_rx_top.sv
test/tb_tcp_rx.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_tcp_rx
FILELIST = src.f

.PHONY: sim clean

# Exit status of the simulation binary is the pass or fail result
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
